// File: compile.f
design/corePkg.sv
design/issueBus.sv
design/instrQueue.sv
design/registerFile.sv
design/decodeStage.sv
design/executeStage.sv
design/writebackStage.sv
design/coreTop.sv
verif/coreChecker.sv
verif/coreTb.sv

// File: verif/coreTb.sv
`timescale 1ns/1ps

module coreTb;

	// Instructions per test
	localparam int nPreload = 16;
	localparam int nRType = 40;
	localparam int nIType = 30;
	localparam int nDepend = 40;
	localparam int nZero = 20;
	localparam int nBackPressure = 40;
	localparam int totalInstr = nPreload + nRType + nIType + nDepend + nZero + nBackPressure;
	localparam int timeoutCycles = totalInstr * 20 + 200;

	// DUT ports
	logic clk;
	logic reset;
	logic instrValid;
	corePkg::instr_t instr;
	logic instrCredit;
	logic wbValid;
	logic wbWrite;
	corePkg::regAddr_t wbAddr;
	corePkg::word_t wbData;
	logic wbCredit;

	// Checker hookup
	logic endCheck;
	int errorCount;

	// Sender and receiver bookkeeping
	int sentCount;
	int creditsGot;
	int recordsSeen;
	int creditsReturned;
	int holdCycles;
	logic holdLong;

	// Test summary
	int testsRun;
	int testsFailed;
	int errsBefore;

	coreTop u_dut (
		.clk(clk),
		.reset(reset),
		.instrValid(instrValid),
		.instr(instr),
		.instrCredit(instrCredit),
		.wbValid(wbValid),
		.wbWrite(wbWrite),
		.wbAddr(wbAddr),
		.wbData(wbData),
		.wbCredit(wbCredit)
	);

	coreChecker uCheck (
		.clk(clk),
		.reset(reset),
		.instrValid(instrValid),
		.instr(instr),
		.instrCredit(instrCredit),
		.wbValid(wbValid),
		.wbWrite(wbWrite),
		.wbAddr(wbAddr),
		.wbData(wbData),
		.wbCredit(wbCredit),
		.endCheck(endCheck),
		.errorCount(errorCount)
	);

	// 8 ns clock
	always #4 clk = ~clk;

	////////////////////////////////////////////////////////////
	// Stream endpoints
	////////////////////////////////////////////////////////////

	// Credits in, records in
	always @(posedge clk)
	begin
		if (!reset)
		begin
			if (instrCredit)
			begin
				creditsGot++;
			end
			if (wbValid)
			begin
				recordsSeen++;
			end
		end
	end

	// Receiver gives back one credit per record after a random hold
	always @(negedge clk)
	begin
		wbCredit = 1'b0;
		if (holdCycles > 0)
		begin
			holdCycles--;
		end
		else if (recordsSeen > creditsReturned)
		begin
			wbCredit = 1'b1;
			creditsReturned++;
			holdCycles = holdLong ? $urandom_range(31) : $urandom_range(2);
		end
	end

	////////////////////////////////////////////////////////////
	// Instruction builders and sender
	////////////////////////////////////////////////////////////

	function automatic corePkg::instr_t rOp(input logic [5:0] fn, input corePkg::regAddr_t rs,
		input corePkg::regAddr_t rt, input corePkg::regAddr_t rd);
		return {corePkg::opRType, rs, rt, rd, 5'b00000, fn};
	endfunction

	function automatic corePkg::instr_t iOp(input logic [5:0] op, input corePkg::regAddr_t rs,
		input corePkg::regAddr_t rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic corePkg::regAddr_t anyReg();
		return corePkg::regAddr_t'($urandom_range(31));
	endfunction

	// One of the six R-type functions
	function automatic logic [5:0] anyFn();
		case ($urandom_range(5))
			0: return corePkg::fnAdd;
			1: return corePkg::fnSub;
			2: return corePkg::fnAnd;
			3: return corePkg::fnOr;
			4: return corePkg::fnXor;
			default: return corePkg::fnSlt;
		endcase
	endfunction

	// Waits on the falling edge until a credit is held
	task automatic sendInstr(input corePkg::instr_t word);
		@(negedge clk);
		while (corePkg::queueDepth + creditsGot - sentCount <= 0)
		begin
			instrValid = 1'b0;
			@(negedge clk);
		end
		instrValid = 1'b1;
		instr = word;
		sentCount++;
	endtask

	task automatic pauseSender(input int cycles);
		repeat (cycles)
		begin
			@(negedge clk);
			instrValid = 1'b0;
		end
	endtask

	// Drain the pipeline, then report the test
	task automatic finishTest(input string name, input int count);
		int errs;
		pauseSender(1);
		while (recordsSeen != sentCount)
		begin
			@(posedge clk);
		end
		pauseSender(1);
		errs = errorCount - errsBefore;
		errsBefore = errorCount;
		testsRun++;
		if (errs != 0)
		begin
			testsFailed++;
		end
		$display("Test %0d %s: %0d instructions, %0d errors, %s", testsRun, name, count, errs,
			(errs == 0) ? "passed" : "failed");
	endtask

	////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////

	task automatic runRTypeMix();
		// Preload r1..r8 with full random words
		for (int r = 1; r <= 8; r++)
		begin
			sendInstr(iOp(corePkg::opLui, 5'd0, corePkg::regAddr_t'(r), 16'($urandom)));
			sendInstr(iOp(corePkg::opOri, corePkg::regAddr_t'(r), corePkg::regAddr_t'(r),
				16'($urandom)));
		end
		for (int i = 0; i < nRType; i++)
		begin
			sendInstr(rOp(anyFn(), anyReg(), anyReg(), anyReg()));
			if ($urandom_range(3) == 0)
			begin
				pauseSender(1 + $urandom_range(3));
			end
		end
		finishTest("random R-type mix", nPreload + nRType);
	endtask

	task automatic runITypeMix();
		logic [5:0] op;
		for (int i = 0; i < nIType; i++)
		begin
			case ($urandom_range(4))
				// Negative immediate
				0: sendInstr(iOp(corePkg::opAddi, anyReg(), anyReg(), {1'b1, 15'($urandom)}));
				1: sendInstr(iOp(corePkg::opOri, anyReg(), anyReg(), 16'($urandom)));
				2: sendInstr(iOp(corePkg::opLui, anyReg(), anyReg(), 16'($urandom)));
				3:
				begin
					// Opcode outside the set
					op = 6'($urandom_range(63));
					if (op == corePkg::opRType || op == corePkg::opAddi || op == corePkg::opOri
						|| op == corePkg::opLui)
					begin
						op = 6'h3f;
					end
					sendInstr(iOp(op, anyReg(), anyReg(), 16'($urandom)));
				end
				// R-type with an unused function code
				default: sendInstr(rOp(6'h00, anyReg(), anyReg(), anyReg()));
			endcase
		end
		finishTest("I-type and unknown encodings", nIType);
	endtask

	task automatic runDependBursts();
		corePkg::regAddr_t prev1;
		corePkg::regAddr_t prev2;
		corePkg::regAddr_t src;
		corePkg::regAddr_t dst;
		prev1 = 5'd1;
		prev2 = 5'd2;
		// Back to back, so forwarding and write-through both fire
		for (int i = 0; i < nDepend; i++)
		begin
			src = $urandom_range(1) ? prev1 : prev2;
			dst = corePkg::regAddr_t'(1 + $urandom_range(30));
			case ($urandom_range(2))
				0: sendInstr(rOp(anyFn(), src, anyReg(), dst));
				1: sendInstr(rOp(anyFn(), anyReg(), src, dst));
				default: sendInstr(iOp(corePkg::opAddi, src, dst, 16'($urandom)));
			endcase
			prev2 = prev1;
			prev1 = dst;
		end
		finishTest("dependency bursts", nDepend);
	endtask

	task automatic runZeroReg();
		for (int i = 0; i < nZero; i++)
		begin
			if (i % 2 == 0)
			begin
				// Aim a write at r0
				if ($urandom_range(1))
				begin
					sendInstr(rOp(anyFn(), anyReg(), anyReg(), 5'd0));
				end
				else
				begin
					sendInstr(iOp(corePkg::opAddi, anyReg(), 5'd0, 16'($urandom)));
				end
			end
			else
			begin
				// Read r0 right behind it
				if ($urandom_range(1))
				begin
					sendInstr(rOp(anyFn(), 5'd0, anyReg(), corePkg::regAddr_t'(1 + $urandom_range(30))));
				end
				else
				begin
					sendInstr(iOp(corePkg::opOri, 5'd0, corePkg::regAddr_t'(1 + $urandom_range(30)),
						16'($urandom)));
				end
			end
		end
		finishTest("register 0", nZero);
	endtask

	task automatic runBackPressure();
		// Long credit holds fill the queue and stall the sender
		holdLong = 1'b1;
		for (int i = 0; i < nBackPressure; i++)
		begin
			if ($urandom_range(1))
			begin
				sendInstr(rOp(anyFn(), anyReg(), anyReg(), anyReg()));
			end
			else
			begin
				sendInstr(iOp(corePkg::opAddi, anyReg(), anyReg(), 16'($urandom)));
			end
		end
		finishTest("output back-pressure", nBackPressure);
		holdLong = 1'b0;
	endtask

	task automatic runCreditBalance();
		@(negedge clk);
		endCheck = 1'b1;
		@(negedge clk);
		endCheck = 1'b0;
		finishTest("credit balance", sentCount);
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence and watchdog
	////////////////////////////////////////////////////////////

	initial
	begin
		void'($urandom(36));
		clk = 1'b0;
		reset = 1'b1;
		instrValid = 1'b0;
		instr = '0;
		wbCredit = 1'b0;
		endCheck = 1'b0;
		holdLong = 1'b0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		runRTypeMix();
		runITypeMix();
		runDependBursts();
		runZeroReg();
		runBackPressure();
		runCreditBalance();
		$display("Summary: %0d tests, %0d passed, %0d failed, %0d errors", testsRun,
			testsRun - testsFailed, testsFailed, errorCount);
		if (testsFailed == 0 && errorCount == 0)
		begin
			$display("Result: PASSED");
		end
		else
		begin
			$display("Result: FAILED");
		end
		$finish;
	end

	// Budget scales with the instruction count
	initial
	begin
		repeat (timeoutCycles + 16) @(posedge clk);
		$display("Watchdog expired after %0d cycles, %0d of %0d records back",
			timeoutCycles, recordsSeen, sentCount);
		$display("Result: FAILED");
		$finish;
	end

endmodule

// File: verif/coreChecker.sv
`timescale 1ns/1ps

module coreChecker (
	input logic clk,
	input logic reset,
	input logic instrValid,
	input corePkg::instr_t instr,
	input logic instrCredit,
	input logic wbValid,
	input logic wbWrite,
	input corePkg::regAddr_t wbAddr,
	input corePkg::word_t wbData,
	input logic wbCredit,
	input logic endCheck,
	output int errorCount
);

	// Architectural state, r0 stays zero
	corePkg::word_t modelRegs [32];

	// Accepted but not yet retired, in order
	corePkg::instr_t inFlight [$];

	// Stream counters
	int accepted;
	int creditPulses;
	int records;
	int outstanding;

	// Prediction for the record at the head
	corePkg::instr_t head;
	logic expWrite;
	corePkg::regAddr_t expAddr;
	corePkg::word_t expData;

	////////////////////////////////////////////////////////////
	// Instruction set model
	////////////////////////////////////////////////////////////

	task automatic predict(input corePkg::instr_t word, output logic wr,
		output corePkg::regAddr_t addr, output corePkg::word_t data);
		corePkg::word_t a;
		corePkg::word_t b;
		logic [15:0] imm;
		a = modelRegs[word[25:21]];
		b = modelRegs[word[20:16]];
		imm = word[15:0];
		// I-type default target is rt
		wr = 1'b1;
		addr = word[20:16];
		data = '0;
		case (word[31:26])
			corePkg::opRType:
			begin
				addr = word[15:11];
				case (word[5:0])
					corePkg::fnAdd: data = a + b;
					corePkg::fnSub: data = a - b;
					corePkg::fnAnd: data = a & b;
					corePkg::fnOr: data = a | b;
					corePkg::fnXor: data = a ^ b;
					corePkg::fnSlt: data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default: wr = 1'b0;
				endcase
			end
			corePkg::opAddi: data = a + {{16{imm[15]}}, imm};
			corePkg::opOri: data = a | {16'h0000, imm};
			corePkg::opLui: data = {imm, 16'h0000};
			// Retires with no write
			default: wr = 1'b0;
		endcase
	endtask

	////////////////////////////////////////////////////////////
	// Port monitor
	////////////////////////////////////////////////////////////

	always @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < 32; i++)
			begin
				modelRegs[i] = '0;
			end
			inFlight.delete();
			accepted = 0;
			creditPulses = 0;
			records = 0;
			outstanding = 0;
		end
		else
		begin
			// Retire first, an instruction never retires on its accept edge
			if (wbValid)
			begin
				records++;
				if (inFlight.size() == 0)
				begin
					$display("Record at %0t ns with no instruction in flight", $time);
					errorCount++;
				end
				else
				begin
					head = inFlight.pop_front();
					predict(head, expWrite, expAddr, expData);
					if (wbWrite !== expWrite)
					begin
						$display("mismatch at %0t ns: wbWrite expected %b, got %b",
							$time, expWrite, wbWrite);
						errorCount++;
					end
					else if (expWrite && (wbAddr !== expAddr))
					begin
						$display("mismatch at %0t ns: wbAddr expected %0d, got %0d",
							$time, expAddr, wbAddr);
						errorCount++;
					end
					else if (expWrite && (wbData !== expData))
					begin
						$display("mismatch at %0t ns: wbData expected %h, got %h",
							$time, expData, wbData);
						errorCount++;
					end
					// Model follows the instruction, not the DUT
					if (expWrite && (expAddr != '0))
					begin
						modelRegs[expAddr] = expData;
					end
				end
			end
			if (instrValid)
			begin
				inFlight.push_back(instr);
				accepted++;
			end
			if (instrCredit)
			begin
				creditPulses++;
				// A freed slot needs an accepted instruction that filled it
				if (creditPulses > accepted)
				begin
					$display("Input credit at %0t ns with no accepted instruction to free",
						$time);
					errorCount++;
				end
			end
			// Records held by the receiver
			outstanding = outstanding + int'(wbValid) - int'(wbCredit);
			if (outstanding > corePkg::outCreditMax)
			begin
				$display("Too many records outstanding at %0t ns: %0d", $time, outstanding);
				errorCount++;
			end
			// End of run balance
			if (endCheck)
			begin
				if (creditPulses != accepted)
				begin
					$display("Credit balance wrong: %0d credits returned for %0d instructions",
						creditPulses, accepted);
					errorCount++;
				end
				if (records != accepted)
				begin
					$display("Record count wrong: %0d records for %0d instructions",
						records, accepted);
					errorCount++;
				end
			end
		end
	end

endmodule

// File: design/coreTop.sv
`timescale 1ns/1ps

module coreTop (
	input logic clk,
	input logic reset,
	// Instruction stream in
	input logic instrValid,
	input corePkg::instr_t instr,
	output logic instrCredit,
	// Write-back stream out
	output logic wbValid,
	output logic wbWrite,
	output corePkg::regAddr_t wbAddr,
	output corePkg::word_t wbData,
	input logic wbCredit
);

	////////////////////////////////////////////////////////////
	// Internal links
	////////////////////////////////////////////////////////////

	// Queue head to decode
	logic headValid;
	corePkg::instr_t headInstr;
	logic pop;

	// Register read addresses
	corePkg::regAddr_t rdAddr1;
	corePkg::regAddr_t rdAddr2;

	// Execute to write-back
	logic resValid;
	logic resWrite;
	corePkg::regAddr_t resDest;
	corePkg::word_t result;

	// Decode to execute
	issueBus iss ();

	////////////////////////////////////////////////////////////
	// Pipeline
	////////////////////////////////////////////////////////////

	instrQueue uQueue (
		.clk(clk),
		.reset(reset),
		.instrValid(instrValid),
		.instr(instr),
		.pop(pop),
		.headValid(headValid),
		.headInstr(headInstr),
		.instrCredit(instrCredit)
	);

	decodeStage uDecode (
		.clk(clk),
		.reset(reset),
		.headValid(headValid),
		.headInstr(headInstr),
		.wbCredit(wbCredit),
		.pop(pop),
		.rdAddr1(rdAddr1),
		.rdAddr2(rdAddr2),
		.iss(iss.producer)
	);

	// Read data lands on the bus alongside the issued instruction
	registerFile uRegs (
		.clk(clk),
		.reset(reset),
		.rdAddr1(rdAddr1),
		.rdAddr2(rdAddr2),
		.wrEn(wbWrite),
		.wrAddr(wbAddr),
		.wrData(wbData),
		.rdData1(iss.rsVal),
		.rdData2(iss.rtVal)
	);

	executeStage uExecute (
		.iss(iss.consumer),
		.wbValid(wbValid),
		.wbWrite(wbWrite),
		.wbAddr(wbAddr),
		.wbData(wbData),
		.resValid(resValid),
		.resWrite(resWrite),
		.resDest(resDest),
		.result(result)
	);

	writebackStage uWriteback (
		.clk(clk),
		.reset(reset),
		.resValid(resValid),
		.resWrite(resWrite),
		.resDest(resDest),
		.result(result),
		.wbValid(wbValid),
		.wbWrite(wbWrite),
		.wbAddr(wbAddr),
		.wbData(wbData)
	);

endmodule

// File: design/writebackStage.sv
`timescale 1ns/1ps

module writebackStage (
	input logic clk,
	input logic reset,
	input logic resValid,
	input logic resWrite,
	input corePkg::regAddr_t resDest,
	input corePkg::word_t result,
	output logic wbValid,
	output logic wbWrite,
	output corePkg::regAddr_t wbAddr,
	output corePkg::word_t wbData
);

	// Control, write only with a valid record
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wbValid <= 1'b0;
			wbWrite <= 1'b0;
		end
		else
		begin
			wbValid <= resValid;
			wbWrite <= resValid && resWrite;
		end
	end

	// Record payload
	always_ff @(posedge clk)
	begin
		wbAddr <= resDest;
		wbData <= result;
	end

endmodule

// File: design/executeStage.sv
`timescale 1ns/1ps

module executeStage (
	issueBus.consumer iss,
	input logic wbValid,
	input logic wbWrite,
	input corePkg::regAddr_t wbAddr,
	input corePkg::word_t wbData,
	output logic resValid,
	output logic resWrite,
	output corePkg::regAddr_t resDest,
	output corePkg::word_t result
);

	// Write-back result usable this cycle
	logic wbLive;

	// Forward hits per operand
	logic fwdRs;
	logic fwdRt;

	// ALU inputs
	corePkg::word_t opA;
	corePkg::word_t rtFwd;
	corePkg::word_t opB;

	////////////////////////////////////////////////////////////
	// Operand forwarding
	////////////////////////////////////////////////////////////

	assign wbLive = wbValid && wbWrite;

	// r0 is never forwarded
	assign fwdRs = wbLive && (wbAddr == iss.rs) && (iss.rs != '0);
	assign fwdRt = wbLive && (wbAddr == iss.rt) && (iss.rt != '0);

	assign opA = fwdRs ? wbData : iss.rsVal;
	assign rtFwd = fwdRt ? wbData : iss.rtVal;

	// I-type takes the extended immediate
	assign opB = iss.useImm ? iss.imm : rtFwd;

	////////////////////////////////////////////////////////////
	// ALU
	////////////////////////////////////////////////////////////

	always_comb
	begin
		case (iss.op)
			corePkg::aluAdd: result = opA + opB;
			corePkg::aluSub: result = opA - opB;
			corePkg::aluAnd: result = opA & opB;
			corePkg::aluOr: result = opA | opB;
			corePkg::aluXor: result = opA ^ opB;
			// Signed compare
			corePkg::aluSlt: result = {31'b0, $signed(opA) < $signed(opB)};
			// Immediate already shifted in decode
			corePkg::aluLui: result = opB;
			default: result = '0;
		endcase
	end

	// Control passes through with the result
	assign resValid = iss.valid;
	assign resWrite = iss.write;
	assign resDest = iss.dest;

endmodule

// File: design/decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
	input logic clk,
	input logic reset,
	input logic headValid,
	input corePkg::instr_t headInstr,
	input logic wbCredit,
	output logic pop,
	output corePkg::regAddr_t rdAddr1,
	output corePkg::regAddr_t rdAddr2,
	issueBus.producer iss
);

	// Output credits in hand
	corePkg::creditCnt_t outCredits;

	// Instruction fields
	logic [5:0] opcode;
	logic [5:0] funct;
	logic [15:0] imm16;

	// Decoded, before the stage register
	corePkg::aluOp_t decOp;
	corePkg::regAddr_t decDest;
	corePkg::word_t decImm;
	logic decUseImm;

	assign opcode = headInstr[31:26];
	assign funct = headInstr[5:0];
	assign imm16 = headInstr[15:0];

	// Issue only with a record slot downstream
	assign pop = headValid && (outCredits != '0);

	// Read addresses straight from the head, data lands with the issue
	assign rdAddr1 = headInstr[25:21];
	assign rdAddr2 = headInstr[20:16];

	////////////////////////////////////////////////////////////
	// Output credit counter
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			outCredits <= corePkg::creditCnt_t'(corePkg::outCreditMax);
		end
		else
		begin
			case ({pop, wbCredit})
				2'b10: outCredits <= outCredits - 1'b1;
				2'b01: outCredits <= outCredits + 1'b1;
				default: outCredits <= outCredits;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Instruction decode
	////////////////////////////////////////////////////////////

	always_comb
	begin
		// Unknown encodings fall through to none
		decOp = corePkg::aluNone;
		decDest = headInstr[20:16];
		decImm = {{16{imm16[15]}}, imm16};
		decUseImm = 1'b1;
		case (opcode)
			corePkg::opRType:
			begin
				decDest = headInstr[15:11];
				decUseImm = 1'b0;
				case (funct)
					corePkg::fnAdd: decOp = corePkg::aluAdd;
					corePkg::fnSub: decOp = corePkg::aluSub;
					corePkg::fnAnd: decOp = corePkg::aluAnd;
					corePkg::fnOr: decOp = corePkg::aluOr;
					corePkg::fnXor: decOp = corePkg::aluXor;
					corePkg::fnSlt: decOp = corePkg::aluSlt;
					default: decOp = corePkg::aluNone;
				endcase
			end
			corePkg::opAddi: decOp = corePkg::aluAdd;
			corePkg::opOri:
			begin
				// Zero extended for the logical op
				decOp = corePkg::aluOr;
				decImm = {16'h0000, imm16};
			end
			corePkg::opLui:
			begin
				// Upper half prepared here, execute just passes it
				decOp = corePkg::aluLui;
				decImm = {imm16, 16'h0000};
			end
			default: decOp = corePkg::aluNone;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Stage register onto the issue bus
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			iss.valid <= 1'b0;
		end
		else
		begin
			iss.valid <= pop;
		end
	end

	// Payload, qualified by valid
	always_ff @(posedge clk)
	begin
		iss.op <= decOp;
		iss.write <= (decOp != corePkg::aluNone);
		iss.useImm <= decUseImm;
		iss.rs <= headInstr[25:21];
		iss.rt <= headInstr[20:16];
		iss.dest <= decDest;
		iss.imm <= decImm;
	end

endmodule

// File: design/registerFile.sv
`timescale 1ns/1ps

module registerFile (
	input logic clk,
	input logic reset,
	input corePkg::regAddr_t rdAddr1,
	input corePkg::regAddr_t rdAddr2,
	input logic wrEn,
	input corePkg::regAddr_t wrAddr,
	input corePkg::word_t wrData,
	output corePkg::word_t rdData1,
	output corePkg::word_t rdData2
);

	// 32 x 32 storage
	corePkg::word_t regs [32];

	// Same-cycle write to a read register
	logic bypass1;
	logic bypass2;

	// Register 0 never bypasses
	assign bypass1 = wrEn && (wrAddr == rdAddr1) && (rdAddr1 != '0);
	assign bypass2 = wrEn && (wrAddr == rdAddr2) && (rdAddr2 != '0);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			// Architectural state starts at zero
			for (int i = 0; i < 32; i++)
			begin
				regs[i] <= '0;
			end
			rdData1 <= '0;
			rdData2 <= '0;
		end
		else
		begin
			// Writes to r0 dropped
			if (wrEn && (wrAddr != '0))
			begin
				regs[wrAddr] <= wrData;
			end
			// Registered reads, write data passed through on a match
			rdData1 <= bypass1 ? wrData : regs[rdAddr1];
			rdData2 <= bypass2 ? wrData : regs[rdAddr2];
		end
	end

endmodule

// File: design/instrQueue.sv
`timescale 1ns/1ps

module instrQueue (
	input logic clk,
	input logic reset,
	input logic instrValid,
	input corePkg::instr_t instr,
	input logic pop,
	output logic headValid,
	output corePkg::instr_t headInstr,
	output logic instrCredit
);

	// Storage, no reset on the payload
	corePkg::instr_t entries [corePkg::queueDepth];

	// Pointers and fill level
	corePkg::queuePtr_t wrPtr;
	corePkg::queuePtr_t rdPtr;
	corePkg::creditCnt_t count;

	// Accepted write this cycle
	logic push;

	// Sender spends credits, so a full queue should never see a push
	assign push = instrValid && (count != corePkg::creditCnt_t'(corePkg::queueDepth));

	// Head of the queue
	assign headValid = (count != '0);
	assign headInstr = entries[rdPtr];

	////////////////////////////////////////////////////////////
	// Payload write
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (push)
		begin
			entries[wrPtr] <= instr;
		end
	end

	////////////////////////////////////////////////////////////
	// Pointers, count and credit return
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			instrCredit <= 1'b0;
		end
		else
		begin
			if (push)
			begin
				wrPtr <= wrPtr + 1'b1;
			end
			if (pop)
			begin
				rdPtr <= rdPtr + 1'b1;
			end
			// Both at once leaves the count alone
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			// One freed slot, one credit, a cycle later
			instrCredit <= pop;
		end
	end

endmodule

// File: design/issueBus.sv
`timescale 1ns/1ps

// Decoded instruction plus its operands, decode to execute
interface issueBus;

	// Stage valid
	logic valid;

	// Decoded operation and its flags
	corePkg::aluOp_t op;
	logic write;
	logic useImm;

	// Source and destination registers
	corePkg::regAddr_t rs;
	corePkg::regAddr_t rt;
	corePkg::regAddr_t dest;

	// Immediate, already extended
	corePkg::word_t imm;

	// Operand values, driven straight from the register file
	corePkg::word_t rsVal;
	corePkg::word_t rtVal;

	// Decode side
	modport producer (output valid, op, write, useImm, rs, rt, dest, imm);

	// Execute side, sees everything
	modport consumer (input valid, op, write, useImm, rs, rt, dest, imm, rsVal, rtVal);

endinterface

// File: design/corePkg.sv
package corePkg;

	////////////////////////////////////////////////////////////
	// Widths with a meaning
	////////////////////////////////////////////////////////////

	// Data word and raw instruction
	typedef logic [31:0] word_t;
	typedef logic [31:0] instr_t;

	// Register index, 32 registers
	typedef logic [4:0] regAddr_t;

	// Credit and occupancy counters, holds 0..4
	typedef logic [2:0] creditCnt_t;

	////////////////////////////////////////////////////////////
	// Sizes
	////////////////////////////////////////////////////////////

	// Queue slots, also the sender's credits after reset
	localparam int queueDepth = 4;

	// Output credits held by decode after reset
	localparam int outCreditMax = 4;

	// Queue pointer, wraps naturally at queueDepth
	typedef logic [$clog2(queueDepth)-1:0] queuePtr_t;

	////////////////////////////////////////////////////////////
	// Encodings
	////////////////////////////////////////////////////////////

	// Opcode field, bits 31:26
	localparam logic [5:0] opRType = 6'h00;
	localparam logic [5:0] opAddi = 6'h08;
	localparam logic [5:0] opOri = 6'h0d;
	localparam logic [5:0] opLui = 6'h0f;

	// Function field of R-type, bits 5:0
	localparam logic [5:0] fnAdd = 6'h20;
	localparam logic [5:0] fnSub = 6'h22;
	localparam logic [5:0] fnAnd = 6'h24;
	localparam logic [5:0] fnOr = 6'h25;
	localparam logic [5:0] fnXor = 6'h26;
	localparam logic [5:0] fnSlt = 6'h2a;

	// ALU operations after decode
	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluSlt,
		aluLui,
		aluNone
	} aluOp_t;

endpackage
